// ==== verilog.f ====
cpu_control_pkg.sv
instruction_decoder.sv
control_sequencer.sv
pc_memory_unit.sv
cpu_control.sv
tb_cpu_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu_control
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_cpu_control.sv ====
`timescale 1ns/1ps

module tb_cpu_control;
        import cpu_control_pkg::*;

        localparam word_t reset_pc        = 16'h0040;
        localparam int    prog_base       = 64;
        localparam int    n_rows          = 29;
        localparam int    halt_row        = 28;
        localparam int    passes          = 2;
        // margin for a four cycle stall after every active cycle
        localparam int    stall_factor    = 5;
        localparam int    watchdog_cycles = passes * (n_rows * 4 * stall_factor + 50);

        localparam logic [3:0] chk_none = 4'd0;
        localparam logic [3:0] chk_reg  = 4'd1;
        localparam logic [3:0] chk_mem  = 4'd2;

        // ====================
        // program table
        // ====================
        // word, cycles, check kind, reg or mem index, expected value, next row
        // row n sits at reset_pc + n, markers write r15 and must be skipped
        localparam logic [55:0] prog_rows [n_rows] = '{
                {16'h0832, 4'd3, chk_reg,  8'd8,  16'h0005, 8'd1},
                {16'h1946, 4'd3, chk_reg,  8'd9,  16'h000a, 8'd2},
                {16'h2a27, 4'd3, chk_reg,  8'd10, 16'h0005, 8'd3},
                {16'h3b39, 4'd3, chk_reg,  8'd11, 16'h0006, 8'd4},
                {16'h4c43, 4'd3, chk_reg,  8'd12, 16'h000c, 8'd5},
                {16'h8d65, 4'd3, chk_reg,  8'd13, 16'hfffb, 8'd6},
                {16'h9e27, 4'd3, chk_reg,  8'd14, 16'h0003, 8'd7},
                {16'ha147, 4'd3, chk_reg,  8'd1,  16'h0003, 8'd8},
                {16'h7052, 4'd3, chk_reg,  8'd0,  16'h0001, 8'd9},
                {16'hb623, 4'd3, chk_reg,  8'd6,  16'h0000, 8'd10},
                {16'h9567, 4'd3, chk_reg,  8'd5,  16'hffff, 8'd11},
                {16'h5843, 4'd4, chk_mem,  8'd7,  16'h0005, 8'd12},
                {16'h6925, 4'd4, chk_reg,  8'd9,  16'h0005, 8'd13},
                {16'h5d08, 4'd4, chk_mem,  8'd9,  16'hfffb, 8'd14},
                {16'h6a36, 4'd4, chk_reg,  8'd10, 16'hfffb, 8'd15},
                {16'hc232, 4'd3, chk_none, 8'd0,  16'h0000, 8'd17},
                {16'h1f01, 4'd3, chk_none, 8'd0,  16'h0000, 8'd17},
                {16'hc322, 4'd3, chk_none, 8'd0,  16'h0000, 8'd18},
                {16'hd332, 4'd3, chk_none, 8'd0,  16'h0000, 8'd20},
                {16'h1f01, 4'd3, chk_none, 8'd0,  16'h0000, 8'd20},
                {16'hd722, 4'd3, chk_none, 8'd0,  16'h0000, 8'd21},
                {16'he892, 4'd3, chk_none, 8'd0,  16'h0000, 8'd23},
                {16'h1f01, 4'd3, chk_none, 8'd0,  16'h0000, 8'd23},
                {16'he232, 4'd3, chk_none, 8'd0,  16'h0000, 8'd24},
                {16'hf003, 4'd3, chk_none, 8'd0,  16'h0000, 8'd27},
                {16'hf003, 4'd3, chk_none, 8'd0,  16'h0000, 8'd28},
                {16'h1f01, 4'd3, chk_none, 8'd0,  16'h0000, 8'd27},
                {16'hfffe, 4'd3, chk_none, 8'd0,  16'h0000, 8'd25},
                {16'hf000, 4'd3, chk_reg,  8'd15, 16'h000f, 8'd28}
        };

        logic      clk;
        logic      reset;
        logic      run_n;
        word_t     sram_d;
        word_t     reg_a;
        word_t     reg_b;
        word_t     alu_out;
        logic      sram_we_n;
        logic      reg_we;
        alu_op_e   alu_op;
        reg_addr_t reg_addr_a;
        reg_addr_t reg_addr_b;
        reg_addr_t reg_addr_c;
        word_t     alu_op_a;
        word_t     reg_data_c;
        word_t     sram_addr;
        word_t     sram_q;

        word_t       mem [256];
        word_t       regs [16];
        int          errors;
        logic [31:0] lfsr;
        logic        stall_en;
        int          stall_left;

        cpu_control #(.reset_pc(reset_pc)) dut (
                .clk(clk), .reset(reset), .run_n(run_n), .sram_d(sram_d),
                .reg_a(reg_a), .reg_b(reg_b), .alu_out(alu_out),
                .sram_we_n(sram_we_n), .reg_we(reg_we), .alu_op(alu_op),
                .reg_addr_a(reg_addr_a), .reg_addr_b(reg_addr_b), .reg_addr_c(reg_addr_c),
                .alu_op_a(alu_op_a), .reg_data_c(reg_data_c),
                .sram_addr(sram_addr), .sram_q(sram_q)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // ====================
        // sram, register file and alu models
        // ====================
        assign sram_d = mem[sram_addr[7:0]];
        assign reg_a  = regs[reg_addr_a];
        assign reg_b  = regs[reg_addr_b];

        always_comb begin
                case (alu_op)
                        alu_add:  alu_out = alu_op_a + reg_b;
                        alu_sub:  alu_out = alu_op_a - reg_b;
                        alu_mult: alu_out = alu_op_a * reg_b;
                        alu_nand: alu_out = ~(alu_op_a & reg_b);
                        // divide by zero gives all ones
                        alu_div:  alu_out = (reg_b == '0) ? '1 : alu_op_a / reg_b;
                        alu_mod:  alu_out = (reg_b == '0) ? '1 : alu_op_a % reg_b;
                        alu_lt:   alu_out = (alu_op_a < reg_b) ? 16'd1 : 16'd0;
                        alu_lte:  alu_out = (alu_op_a <= reg_b) ? 16'd1 : 16'd0;
                        default:  alu_out = '0;
                endcase
        end

        // reset reloads the program, fill elsewhere, and r[i] = i
        always @(posedge clk or negedge reset) begin : model_seq
                int i;
                if (!reset) begin
                        for (i = 0; i < 256; i++) begin
                                if (i >= prog_base && i < prog_base + n_rows)
                                        mem[8'(i)] <= prog_rows[5'(i - prog_base)][55:40];
                                else
                                        mem[8'(i)] <= {8'ha5, 8'(i)};
                        end
                        for (i = 0; i < 16; i++)
                                regs[4'(i)] <= 16'(i);
                end else begin
                        if (!sram_we_n)
                                mem[sram_addr[7:0]] <= sram_q;
                        if (reg_we)
                                regs[reg_addr_c] <= reg_data_c;
                end
        end

        // fibonacci lfsr, taps 32 22 2 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                logic fb;
                fb = s[31] ^ s[21] ^ s[1] ^ s[0];
                return {s[30:0], fb};
        endfunction

        function automatic logic [3:0] take_bits(input int n);
                logic [3:0] v;
                int         k;
                v = '0;
                for (k = 0; k < n; k++) begin
                        v    = {v[2:0], lfsr[0]};
                        lfsr = lfsr_next(lfsr);
                end
                return v;
        endfunction

        // stall of 1 to 4 cycles starts with odds of one in four
        function automatic logic stall_cycle();
                if (!stall_en)
                        return 1'b0;
                if (stall_left == 0 && take_bits(2) == 4'd0)
                        stall_left = int'(take_bits(2)) + 1;
                if (stall_left > 0) begin
                        stall_left--;
                        return 1'b1;
                end
                return 1'b0;
        endfunction

        // ====================
        // one instruction, entered and left on a falling edge
        // ====================
        task automatic run_row(input logic [4:0] row, output logic [4:0] nxt);
                word_t       pc;
                logic [15:0] word;
                logic [3:0]  opc;
                int          cycles;
                int          active;
                int          we_cnt;
                int          wen_cnt;
                int          exp_we;
                int          exp_wen;
                logic        held;
                logic [47:0] snap;
                logic [47:0] held_snap;
                pc      = reset_pc + 16'(row);
                word    = prog_rows[row][55:40];
                opc     = word[15:12];
                cycles  = int'(prog_rows[row][39:36]);
                nxt     = prog_rows[row][4:0];
                active  = 0;
                we_cnt  = 0;
                wen_cnt = 0;
                held    = 1'b0;
                while (active < cycles) begin
                        run_n = stall_cycle();
                        #1;
                        snap = {sram_addr, sram_q, sram_we_n, reg_addr_a, reg_addr_b,
                                reg_addr_c, alu_op};
                        if (held && snap !== held_snap) begin
                                $display("FAIL %0t: row %0d outputs moved during a stall",
                                         $time, row);
                                errors++;
                        end
                        if (run_n) begin
                                if (reg_we !== 1'b0) begin
                                        $display("FAIL %0t: row %0d reg_we high in a stall",
                                                 $time, row);
                                        errors++;
                                end
                                held      = 1'b1;
                                held_snap = snap;
                        end else begin
                                held = 1'b0;
                                // fetch, decode and execute still address the pc
                                if (active < 3 && sram_addr !== pc) begin
                                        $display("FAIL %0t: row %0d sram_addr %h, pc %h",
                                                 $time, row, sram_addr, pc);
                                        errors++;
                                end
                                if (reg_we === 1'b1)
                                        we_cnt++;
                                if (sram_we_n === 1'b0)
                                        wen_cnt++;
                                active++;
                        end
                        @(posedge clk);
                        @(negedge clk);
                end
                // alu ops and lw write back once, sw strobes once
                exp_we  = (opc == 4'd5 || opc >= 4'd12) ? 0 : 1;
                exp_wen = (opc == 4'd5) ? 1 : 0;
                if (we_cnt != exp_we || wen_cnt != exp_wen) begin
                        $display("FAIL %0t: row %0d reg_we %0d and sram_we_n %0d cycles",
                                 $time, row, we_cnt, wen_cnt);
                        errors++;
                end
                if (prog_rows[row][35:32] == chk_reg &&
                    regs[prog_rows[row][27:24]] !== prog_rows[row][23:8]) begin
                        $display("FAIL %0t: row %0d register value wrong", $time, row);
                        errors++;
                end
                if (prog_rows[row][35:32] == chk_mem &&
                    mem[prog_rows[row][31:24]] !== prog_rows[row][23:8]) begin
                        $display("FAIL %0t: row %0d memory value wrong", $time, row);
                        errors++;
                end
                if (sram_addr !== reset_pc + 16'(nxt)) begin
                        $display("FAIL %0t: row %0d next fetch at %h", $time, row, sram_addr);
                        errors++;
                end
        endtask

        initial begin
                logic [4:0] row;
                logic [4:0] nxt;
                logic       done;
                int         pass;
                errors     = 0;
                reset      = 1'b0;
                run_n      = 1'b1;
                lfsr       = 32'hcab9;
                stall_en   = 1'b0;
                stall_left = 0;
                // first pass runs clean, second pass with random stalls
                for (pass = 0; pass < passes; pass++) begin
                        stall_en = (pass == 1);
                        // each pass starts on a falling edge
                        reset = 1'b0;
                        run_n = 1'b1;
                        repeat (5) @(negedge clk);
                        reset = 1'b1;
                        #1;
                        if (sram_addr !== reset_pc || sram_we_n !== 1'b1 || reg_we !== 1'b0 ||
                            sram_q !== 16'hffff) begin
                                $display("FAIL %0t: outputs wrong after reset", $time);
                                errors++;
                        end
                        @(negedge clk);
                        row = 5'd0;
                        do begin
                                run_row(row, nxt);
                                done = (row == 5'(halt_row));
                                row  = nxt;
                        end while (!done);
                end
                $display("run finished with %0d errors", errors);
                if (errors == 0)
                        $display("all tests passed");
                else
                        $display("tests failed");
                $finish;
        end

        // watchdog
        initial begin
                repeat (watchdog_cycles) @(posedge clk);
                $display("watchdog expired before the program reached its halt row");
                $display("tests failed");
                $finish;
        end

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control #(
        parameter cpu_control_pkg::word_t reset_pc = '0
) (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            run_n,
        input  cpu_control_pkg::word_t          sram_d,
        input  cpu_control_pkg::word_t          reg_a,
        // feeds the external alu only
        input  cpu_control_pkg::word_t          reg_b,
        input  cpu_control_pkg::word_t          alu_out,
        output logic                            sram_we_n,
        output logic                            reg_we,
        output cpu_control_pkg::alu_op_e        alu_op,
        output cpu_control_pkg::reg_addr_t      reg_addr_a,
        output cpu_control_pkg::reg_addr_t      reg_addr_b,
        output cpu_control_pkg::reg_addr_t      reg_addr_c,
        output cpu_control_pkg::word_t          alu_op_a,
        output cpu_control_pkg::word_t          reg_data_c,
        output cpu_control_pkg::word_t          sram_addr,
        output cpu_control_pkg::word_t          sram_q
);
        import cpu_control_pkg::*;

        // sequencer to decoder and pc unit
        phase_e                 phase;
        logic                   stall_hold;
        // decoder to sequencer and pc unit
        op_class_e              op_class;
        opcode_e                opcode;
        logic [imm_width-1:0]   imm;
        logic [jump_width-1:0]  jump_offset;

        control_sequencer u_sequencer (
                .clk        (clk),
                .reset      (reset),
                .run_n      (run_n),
                .op_class   (op_class),
                .phase      (phase),
                .stall_hold (stall_hold)
        );

        instruction_decoder u_decoder (
                .clk         (clk),
                .reset       (reset),
                .stall_hold  (stall_hold),
                .phase       (phase),
                .sram_d      (sram_d),
                .reg_a       (reg_a),
                .opcode      (opcode),
                .op_class    (op_class),
                .imm         (imm),
                .jump_offset (jump_offset),
                .reg_addr_a  (reg_addr_a),
                .reg_addr_b  (reg_addr_b),
                .reg_addr_c  (reg_addr_c),
                .alu_op      (alu_op),
                .alu_op_a    (alu_op_a),
                .reg_we      (reg_we)
        );

        pc_memory_unit #(
                .reset_pc (reset_pc)
        ) u_pc_memory (
                .clk         (clk),
                .reset       (reset),
                .stall_hold  (stall_hold),
                .phase       (phase),
                .opcode      (opcode),
                .imm         (imm),
                .jump_offset (jump_offset),
                .alu_out     (alu_out),
                .reg_a       (reg_a),
                .sram_d      (sram_d),
                .sram_addr   (sram_addr),
                .sram_q      (sram_q),
                .reg_data_c  (reg_data_c),
                .sram_we_n   (sram_we_n)
        );

endmodule

// ==== pc_memory_unit.sv ====
`timescale 1ns/1ps

module pc_memory_unit #(
        parameter cpu_control_pkg::word_t reset_pc = '0
) (
        input  logic                                      clk,
        input  logic                                      reset,
        input  logic                                      stall_hold,
        input  cpu_control_pkg::phase_e                   phase,
        input  cpu_control_pkg::opcode_e                  opcode,
        input  logic [cpu_control_pkg::imm_width-1:0]     imm,
        input  logic [cpu_control_pkg::jump_width-1:0]    jump_offset,
        input  cpu_control_pkg::word_t                    alu_out,
        input  cpu_control_pkg::word_t                    reg_a,
        input  cpu_control_pkg::word_t                    sram_d,
        output cpu_control_pkg::word_t                    sram_addr,
        output cpu_control_pkg::word_t                    sram_q,
        output cpu_control_pkg::word_t                    reg_data_c,
        output logic                                      sram_we_n
);
        import cpu_control_pkg::*;

        word_t pc;
        word_t next_pc;
        word_t pc_plus_one;
        word_t branch_target;
        word_t jump_target;
        logic  branch_taken;
        logic  is_mem;
        logic  is_store;
        logic  last_phase;

        assign is_store = (opcode == op_sw);
        assign is_mem   = is_store || (opcode == op_lw);

        // execute ends the instruction except for lw and sw
        assign last_phase = (phase == phase_memory) ||
                            (phase == phase_execute && !is_mem);

        // ====================
        // next pc
        // ====================
        assign pc_plus_one   = pc + word_t'(1);
        // branch offset is unsigned
        assign branch_target = pc + word_t'(imm);
        // jump offset is signed, no correction term
        assign jump_target   = pc + {{($bits(word_t) - jump_width){jump_offset[jump_width-1]}},
                                     jump_offset};

        // decided in execute while op3 and op2 still feed the alu
        always_comb begin
                case (opcode)
                        op_blt, op_ble: branch_taken = (alu_out == word_t'(1));
                        op_beq:         branch_taken = (alu_out == '0);
                        default:        branch_taken = 1'b0;
                endcase
        end

        always_comb begin
                if (opcode == op_jump)
                        next_pc = jump_target;
                else if (branch_taken)
                        next_pc = branch_target;
                else
                        next_pc = pc_plus_one;
        end

        // ====================
        // pc and sram port
        // ====================
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        pc        <= reset_pc;
                        sram_addr <= reset_pc;
                        sram_q    <= '1;
                        sram_we_n <= 1'b1;
                end else if (!stall_hold) begin
                        if (last_phase) begin
                                // next fetch reads from the new pc
                                pc        <= next_pc;
                                sram_addr <= next_pc;
                                sram_we_n <= 1'b1;
                        end else if (phase == phase_execute) begin
                                // lw or sw: pointer plus immediate from the alu
                                sram_addr <= alu_out;
                                sram_we_n <= !is_store;
                                // store data comes from op3 on port a
                                if (is_store)
                                        sram_q <= reg_a;
                        end
                end
        end

        // load data only in the memory phase of lw
        assign reg_data_c = (phase == phase_memory && opcode == op_lw) ? sram_d : alu_out;

        // write strobe confined to the memory phase
        a_we_in_memory: assert property (
                @(posedge clk) disable iff (!reset)
                !sram_we_n |-> (phase == phase_memory && is_store)
        );

endmodule

// ==== control_sequencer.sv ====
`timescale 1ns/1ps

module control_sequencer (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            run_n,
        input  cpu_control_pkg::op_class_e      op_class,
        output cpu_control_pkg::phase_e         phase,
        output logic                            stall_hold
);
        import cpu_control_pkg::*;

        phase_e phase_next;
        logic   is_mem_class;

        // run_n high freezes every register in the unit
        assign stall_hold = run_n;

        // only loads and stores need the memory phase
        assign is_mem_class = (op_class == class_load) || (op_class == class_store);

        // ====================
        // phase sequence
        // ====================
        always_comb begin
                case (phase)
                        phase_fetch:   phase_next = phase_decode;
                        phase_decode:  phase_next = phase_execute;
                        // class is valid once the instruction is captured
                        phase_execute: phase_next = is_mem_class ? phase_memory : phase_fetch;
                        phase_memory:  phase_next = phase_fetch;
                        default:       phase_next = phase_fetch;
                endcase
        end

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        phase <= phase_fetch;
                end else if (!stall_hold) begin
                        phase <= phase_next;
                end
        end

        // ====================
        // checks
        // ====================

        // memory phase only under a load or store
        a_memory_class: assert property (
                @(posedge clk) disable iff (!reset)
                phase == phase_memory |-> is_mem_class
        );

        // execute lasts one cycle unless stalled
        a_execute_leaves: assert property (
                @(posedge clk) disable iff (!reset)
                (phase == phase_execute && !run_n) |=> phase != phase_execute
        );

endmodule

// ==== instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder (
        input  logic                                      clk,
        input  logic                                      reset,
        input  logic                                      stall_hold,
        input  cpu_control_pkg::phase_e                   phase,
        input  cpu_control_pkg::word_t                    sram_d,
        input  cpu_control_pkg::word_t                    reg_a,
        output cpu_control_pkg::opcode_e                  opcode,
        output cpu_control_pkg::op_class_e                op_class,
        output logic [cpu_control_pkg::imm_width-1:0]     imm,
        output logic [cpu_control_pkg::jump_width-1:0]    jump_offset,
        output cpu_control_pkg::reg_addr_t                reg_addr_a,
        output cpu_control_pkg::reg_addr_t                reg_addr_b,
        output cpu_control_pkg::reg_addr_t                reg_addr_c,
        output cpu_control_pkg::alu_op_e                  alu_op,
        output cpu_control_pkg::word_t                    alu_op_a,
        output logic                                      reg_we
);
        import cpu_control_pkg::*;

        word_t     instr;
        reg_addr_t op1;
        reg_addr_t op2;
        reg_addr_t op3;
        logic      imm_en;

        // instruction register, loaded from sram at the end of fetch
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        instr <= '0;
                end else if (phase == phase_fetch && !stall_hold) begin
                        instr <= sram_d;
                end
        end

        // ====================
        // field split
        // ====================
        assign opcode      = opcode_e'(instr[15:12]);
        assign op3         = instr[11:8];
        assign op2         = instr[7:4];
        assign op1         = instr[3:0];
        // immediate and branch offset share the low nibble
        assign imm         = instr[imm_width-1:0];
        assign jump_offset = instr[jump_width-1:0];

        // class and alu code per opcode
        always_comb begin
                op_class = class_alu;
                alu_op   = alu_add;
                imm_en   = 1'b0;
                case (opcode)
                        op_addi: imm_en = 1'b1;
                        op_sub:  alu_op = alu_sub;
                        op_subi: begin
                                alu_op = alu_sub;
                                imm_en = 1'b1;
                        end
                        op_mult: alu_op = alu_mult;
                        op_nand: alu_op = alu_nand;
                        op_div:  alu_op = alu_div;
                        op_mod:  alu_op = alu_mod;
                        op_lt:   alu_op = alu_lt;
                        op_lte:  alu_op = alu_lte;
                        // memory: alu forms pointer plus immediate
                        op_sw: begin
                                op_class = class_store;
                                imm_en   = 1'b1;
                        end
                        op_lw: begin
                                op_class = class_load;
                                imm_en   = 1'b1;
                        end
                        // branches compare op3 against op2
                        op_blt: begin
                                op_class = class_branch;
                                alu_op   = alu_lt;
                        end
                        op_ble: begin
                                op_class = class_branch;
                                alu_op   = alu_lte;
                        end
                        // equal when the difference is zero
                        op_beq: begin
                                op_class = class_branch;
                                alu_op   = alu_sub;
                        end
                        op_jump: op_class = class_jump;
                        // plain add keeps the defaults
                        default: alu_op = alu_add;
                endcase
        end

        // register addresses
        always_comb begin
                reg_addr_a = op1;
                reg_addr_b = op2;
                reg_addr_c = op3;
                // store data and branch operand sit in op3
                if (op_class != class_alu)
                        reg_addr_a = op3;
        end

        // zero-extended immediate replaces port a
        assign alu_op_a = imm_en ? word_t'(imm) : reg_a;

        // write-back: alu result in execute, load data in memory
        assign reg_we = !stall_hold &&
                        ((phase == phase_execute && op_class == class_alu) ||
                         (phase == phase_memory && op_class == class_load));

endmodule

// ==== cpu_control_pkg.sv ====
// ====================
// shared types for the control unit
// ====================
package cpu_control_pkg;

        // data, instruction and address word
        typedef logic [15:0] word_t;

        // register file address, sixteen entries
        typedef logic [3:0] reg_addr_t;

        // field widths inside the instruction word
        localparam int jump_width = 12;
        localparam int imm_width  = 4;

        // opcode in bits 15:12
        typedef enum logic [3:0] {
                op_add  = 4'd0,
                op_addi = 4'd1,
                op_sub  = 4'd2,
                op_subi = 4'd3,
                op_mult = 4'd4,
                op_sw   = 4'd5,
                op_lw   = 4'd6,
                op_lt   = 4'd7,
                op_nand = 4'd8,
                op_div  = 4'd9,
                op_mod  = 4'd10,
                op_lte  = 4'd11,
                op_blt  = 4'd12,
                op_ble  = 4'd13,
                op_beq  = 4'd14,
                op_jump = 4'd15
        } opcode_e;

        // codes understood by the external ALU
        typedef enum logic [2:0] {
                alu_add  = 3'd0,
                alu_sub  = 3'd1,
                alu_mult = 3'd2,
                alu_nand = 3'd3,
                alu_div  = 3'd4,
                alu_mod  = 3'd5,
                alu_lt   = 3'd6,
                alu_lte  = 3'd7
        } alu_op_e;

        // instruction classes, these pick the phase sequence
        typedef enum logic [2:0] {
                class_alu,
                class_load,
                class_store,
                class_branch,
                class_jump
        } op_class_e;

        // control phases, one per cycle
        typedef enum logic [1:0] {
                phase_fetch,
                phase_decode,
                phase_execute,
                phase_memory
        } phase_e;

endpackage
